// File: common/kl_pkg.sv
`default_nettype none

package kl_pkg;

    // KLink bus widths
    localparam int KL_ADDR_W = 32;
    localparam int KL_DATA_W = 64;
    localparam int KL_MASK_W = KL_DATA_W / 8;
    localparam int KL_SIZE_W = 3;
    localparam int KL_ID_W   = 5;

    typedef logic [KL_ADDR_W-1:0] kl_addr_t;
    typedef logic [KL_DATA_W-1:0] kl_data_t;
    typedef logic [KL_ID_W-1:0]   kl_src_id_t;
    typedef logic [KL_SIZE_W-1:0] kl_size_t;

    // Request beat. Masters leave srcid at zero, the arbiter fills it in
    typedef struct packed {
        kl_addr_t             addr;
        logic                 wen;
        kl_data_t             wdata;
        logic [KL_MASK_W-1:0] wmask;
        kl_size_t             size;
        kl_src_id_t           srcid;
    } kl_req_t;

    // Response beat, routed back to the master named by dstid
    typedef struct packed {
        kl_data_t   rdata;
        kl_size_t   size;
        kl_src_id_t dstid;
    } kl_resp_t;

    // Size is log2 of the byte count, and anything up to 8 bytes is one beat
    function automatic int unsigned kl_beats(input kl_size_t size);
        if (size <= kl_size_t'(3)) begin
            return 1;
        end else begin
            return 1 << (size - kl_size_t'(3));
        end
    endfunction

endpackage

`default_nettype wire

// File: rtl/round_robin_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

// Round-robin grant over WIDTH requesters
// The requester after the last granted one has the highest priority
module round_robin_arbiter #(
    parameter int WIDTH = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             enable,
    input  logic [WIDTH-1:0] request,
    output logic [WIDTH-1:0] grant
);

    localparam int PTR_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    logic [PTR_W-1:0] prio_ptr;
    logic [PTR_W-1:0] grant_idx;

    // Walk from lowest to highest priority so that the last hit wins
    always_comb begin
        int unsigned idx;
        grant = '0;
        grant_idx = prio_ptr;
        for (int off = WIDTH - 1; off >= 0; off--) begin
            idx = (int'(prio_ptr) + off) % WIDTH;
            if (request[idx]) begin
                grant = '0;
                grant[idx] = 1'b1;
                grant_idx = PTR_W'(idx);
            end
        end
    end

    // The granted requester drops to lowest priority
    always_ff @(posedge clk) begin
        if (rst) begin
            prio_ptr <= '0;
        end else if (enable && (|grant)) begin
            if (int'(grant_idx) == WIDTH - 1) begin
                prio_ptr <= '0;
            end else begin
                prio_ptr <= grant_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: kl_arbiter/kl_arbiter_2by1.sv
`timescale 1ns/1ps
`default_nettype none

// KLink arbiter joining two uplinks onto one downlink
module kl_arbiter_2by1 #(
    parameter int                 MAX_BURST_WIDTH = 5,
    parameter kl_pkg::kl_src_id_t UP0_SRC_ID      = 5'd0,
    parameter kl_pkg::kl_src_id_t UP1_SRC_ID      = 5'd1
) (
    input  logic             clk,
    input  logic             rst,
    // Uplinks
    input  kl_pkg::kl_req_t  up0_req,
    input  logic             up0_req_valid,
    output logic             up0_req_ready,
    output kl_pkg::kl_resp_t up0_resp,
    output logic             up0_resp_valid,
    input  logic             up0_resp_ready,
    input  kl_pkg::kl_req_t  up1_req,
    input  logic             up1_req_valid,
    output logic             up1_req_ready,
    output kl_pkg::kl_resp_t up1_resp,
    output logic             up1_resp_valid,
    input  logic             up1_resp_ready,
    // Downlink
    output kl_pkg::kl_req_t  dn_req,
    output logic             dn_req_valid,
    input  logic             dn_req_ready,
    input  kl_pkg::kl_resp_t dn_resp,
    input  logic             dn_resp_valid,
    output logic             dn_resp_ready
);

    import kl_pkg::*;

    typedef enum logic [1:0] {CONN_UP0, CONN_UP1, CONN_NONE} conn_e;
    typedef enum logic {ST_IDLE, ST_BURST} burst_state_e;

    // Request channel
    burst_state_e               req_state;
    conn_e                      req_lock_conn;
    conn_e                      req_grant_conn;
    conn_e                      req_conn;
    logic [1:0]                 req_grant;
    logic [MAX_BURST_WIDTH-1:0] req_left;
    logic [MAX_BURST_WIDTH-1:0] req_beats;
    logic                       req_fire;

    round_robin_arbiter #(.WIDTH(2)) req_rr_inst (
        .clk     (clk),
        .rst     (rst),
        .enable  ((req_state == ST_IDLE) && dn_req_ready),
        .request ({up1_req_valid, up0_req_valid}),
        .grant   (req_grant)
    );

    assign req_grant_conn = req_grant[0] ? CONN_UP0 : (req_grant[1] ? CONN_UP1 : CONN_NONE);
    assign req_conn = (req_state == ST_IDLE) ? req_grant_conn : req_lock_conn;
    assign req_fire = dn_req_valid && dn_req_ready;
    assign req_beats = MAX_BURST_WIDTH'(kl_beats(dn_req.size));

    // Only a write burst holds the connection past its first beat
    always_ff @(posedge clk) begin
        if (rst) begin
            req_state <= ST_IDLE;
            req_lock_conn <= CONN_NONE;
            req_left <= '0;
        end else if (req_fire) begin
            if (req_state == ST_IDLE) begin
                if (dn_req.wen && (req_beats > MAX_BURST_WIDTH'(1))) begin
                    req_state <= ST_BURST;
                    req_lock_conn <= req_conn;
                    req_left <= req_beats - 1'b1;
                end
            end else begin
                if (req_left == MAX_BURST_WIDTH'(1)) begin
                    req_state <= ST_IDLE;
                    req_lock_conn <= CONN_NONE;
                end
                req_left <= req_left - 1'b1;
            end
        end
    end

    // Response channel
    burst_state_e               resp_state;
    conn_e                      resp_lock_conn;
    conn_e                      resp_decode;
    conn_e                      resp_conn;
    logic [MAX_BURST_WIDTH-1:0] resp_left;
    logic [MAX_BURST_WIDTH-1:0] resp_beats;

    assign resp_decode = (dn_resp.dstid == UP0_SRC_ID) ? CONN_UP0 :
                         ((dn_resp.dstid == UP1_SRC_ID) ? CONN_UP1 : CONN_NONE);
    assign resp_conn = (resp_state == ST_BURST) ? resp_lock_conn :
                       (dn_resp_valid ? resp_decode : CONN_NONE);
    assign resp_beats = MAX_BURST_WIDTH'(kl_beats(dn_resp.size));

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_state <= ST_IDLE;
            resp_lock_conn <= CONN_NONE;
            resp_left <= '0;
        end else if (dn_resp_valid && dn_resp_ready) begin
            if (resp_state == ST_IDLE) begin
                if (resp_beats > MAX_BURST_WIDTH'(1)) begin
                    resp_state <= ST_BURST;
                    resp_lock_conn <= resp_decode;
                    resp_left <= resp_beats - 1'b1;
                end
            end else begin
                if (resp_left == MAX_BURST_WIDTH'(1)) begin
                    resp_state <= ST_IDLE;
                    resp_lock_conn <= CONN_NONE;
                end
                resp_left <= resp_left - 1'b1;
            end
        end
    end

    // Steering, with the srcid stamped on the way down
    always_comb begin
        up0_req_ready = 1'b0;
        up1_req_ready = 1'b0;
        dn_req = '0;
        dn_req_valid = 1'b0;
        if (req_conn == CONN_UP0) begin
            dn_req = up0_req;
            dn_req.srcid = UP0_SRC_ID;
            dn_req_valid = up0_req_valid;
            up0_req_ready = dn_req_ready;
        end else if (req_conn == CONN_UP1) begin
            dn_req = up1_req;
            dn_req.srcid = UP1_SRC_ID;
            dn_req_valid = up1_req_valid;
            up1_req_ready = dn_req_ready;
        end
    end

    // Both uplinks see the response payload, only the routed one sees valid
    assign up0_resp = dn_resp;
    assign up1_resp = dn_resp;
    assign up0_resp_valid = (resp_conn == CONN_UP0) && dn_resp_valid;
    assign up1_resp_valid = (resp_conn == CONN_UP1) && dn_resp_valid;
    assign dn_resp_ready = ((resp_conn == CONN_UP0) && up0_resp_ready) ||
                           ((resp_conn == CONN_UP1) && up1_resp_ready);

endmodule

`default_nettype wire

// File: rtl/kl_ram.sv
`timescale 1ns/1ps
`default_nettype none

// KLink memory target. Writes are byte masked, reads stream one beat per word
module kl_ram #(
    parameter int MAX_BURST_WIDTH = 5,
    parameter int MEM_WORDS       = 256
) (
    input  logic             clk,
    input  logic             rst,
    input  kl_pkg::kl_req_t  req,
    input  logic             req_valid,
    output logic             req_ready,
    output kl_pkg::kl_resp_t resp,
    output logic             resp_valid,
    input  logic             resp_ready
);

    import kl_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    kl_data_t                   mem [MEM_WORDS];
    logic [AW-1:0]              req_word;
    logic [AW-1:0]              wr_word;
    logic [AW-1:0]              wr_base;
    logic [AW-1:0]              rd_next;
    logic [MAX_BURST_WIDTH-1:0] req_beats;
    logic [MAX_BURST_WIDTH-1:0] wr_idx;
    logic [MAX_BURST_WIDTH-1:0] rd_left;
    logic                       wr_fire;
    logic                       rd_fire;
    logic                       resp_fire;

    // A pending or running read blocks new requests
    assign req_ready = !resp_valid;

    // Low three address bits select a byte and are ignored
    assign req_word = req.addr[AW+2:3];
    assign req_beats = MAX_BURST_WIDTH'(kl_beats(req.size));
    assign wr_word = (wr_idx == '0) ? req_word : wr_base + AW'(wr_idx);
    assign wr_fire = req_valid && req_ready && req.wen;
    assign rd_fire = req_valid && req_ready && !req.wen;
    assign resp_fire = resp_valid && resp_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_idx <= '0;
            rd_left <= '0;
            resp_valid <= 1'b0;
        end else begin
            if (wr_fire) begin
                if (wr_idx == req_beats - 1'b1) begin
                    wr_idx <= '0;
                end else begin
                    wr_idx <= wr_idx + 1'b1;
                end
            end
            if (rd_fire) begin
                resp_valid <= 1'b1;
                rd_left <= req_beats - 1'b1;
            end else if (resp_fire) begin
                if (rd_left == '0) begin
                    resp_valid <= 1'b0;
                end else begin
                    rd_left <= rd_left - 1'b1;
                end
            end
        end
    end

    // Storage and read data. The next word is fetched at each beat transfer
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            if (wr_idx == '0) begin
                wr_base <= req_word;
            end
            for (int b = 0; b < KL_MASK_W; b++) begin
                if (req.wmask[b]) begin
                    mem[wr_word][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
        if (rd_fire) begin
            resp.rdata <= mem[req_word];
            resp.size <= req.size;
            resp.dstid <= req.srcid;
            rd_next <= req_word + 1'b1;
        end else if (resp_fire && (rd_left != '0)) begin
            resp.rdata <= mem[rd_next];
            rd_next <= rd_next + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/kl_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

// Two KLink masters sharing one RAM through the 2-to-1 arbiter
module kl_subsys_top #(
    parameter int                 MAX_BURST_WIDTH = 5,
    parameter kl_pkg::kl_src_id_t UP0_SRC_ID      = 5'd0,
    parameter kl_pkg::kl_src_id_t UP1_SRC_ID      = 5'd1,
    parameter int                 MEM_WORDS       = 256
) (
    input  logic             clk,
    input  logic             rst,
    input  kl_pkg::kl_req_t  up0_req,
    input  logic             up0_req_valid,
    output logic             up0_req_ready,
    output kl_pkg::kl_resp_t up0_resp,
    output logic             up0_resp_valid,
    input  logic             up0_resp_ready,
    input  kl_pkg::kl_req_t  up1_req,
    input  logic             up1_req_valid,
    output logic             up1_req_ready,
    output kl_pkg::kl_resp_t up1_resp,
    output logic             up1_resp_valid,
    input  logic             up1_resp_ready
);

    import kl_pkg::*;

    kl_req_t  dn_req;
    logic     dn_req_valid;
    logic     dn_req_ready;
    kl_resp_t dn_resp;
    logic     dn_resp_valid;
    logic     dn_resp_ready;

    kl_arbiter_2by1 #(
        .MAX_BURST_WIDTH (MAX_BURST_WIDTH),
        .UP0_SRC_ID      (UP0_SRC_ID),
        .UP1_SRC_ID      (UP1_SRC_ID)
    ) kl_arbiter_2by1_inst (
        .clk            (clk),
        .rst            (rst),
        .up0_req        (up0_req),
        .up0_req_valid  (up0_req_valid),
        .up0_req_ready  (up0_req_ready),
        .up0_resp       (up0_resp),
        .up0_resp_valid (up0_resp_valid),
        .up0_resp_ready (up0_resp_ready),
        .up1_req        (up1_req),
        .up1_req_valid  (up1_req_valid),
        .up1_req_ready  (up1_req_ready),
        .up1_resp       (up1_resp),
        .up1_resp_valid (up1_resp_valid),
        .up1_resp_ready (up1_resp_ready),
        .dn_req         (dn_req),
        .dn_req_valid   (dn_req_valid),
        .dn_req_ready   (dn_req_ready),
        .dn_resp        (dn_resp),
        .dn_resp_valid  (dn_resp_valid),
        .dn_resp_ready  (dn_resp_ready)
    );

    kl_ram #(
        .MAX_BURST_WIDTH (MAX_BURST_WIDTH),
        .MEM_WORDS       (MEM_WORDS)
    ) kl_ram_inst (
        .clk        (clk),
        .rst        (rst),
        .req        (dn_req),
        .req_valid  (dn_req_valid),
        .req_ready  (dn_req_ready),
        .resp       (dn_resp),
        .resp_valid (dn_resp_valid),
        .resp_ready (dn_resp_ready)
    );

endmodule

`default_nettype wire

// File: verif/kl_subsys_sva.sv
`timescale 1ns/1ps
`default_nettype none

// Protocol checks on the KLink arbiter, bound into every instance
module kl_subsys_sva #(
    parameter kl_pkg::kl_src_id_t UP0_SRC_ID = 5'd0,
    parameter kl_pkg::kl_src_id_t UP1_SRC_ID = 5'd1
) (
    input logic             clk,
    input logic             rst,
    input kl_pkg::kl_req_t  up0_req,
    input logic             up0_req_valid,
    input logic             up0_req_ready,
    input kl_pkg::kl_req_t  up1_req,
    input logic             up1_req_valid,
    input logic             up1_req_ready,
    input logic             up0_resp_valid,
    input logic             up1_resp_valid,
    input kl_pkg::kl_resp_t dn_resp,
    input logic             dn_resp_valid,
    input logic             dn_resp_ready
);

    import kl_pkg::*;

    int          fail_count = 0;
    logic        up0_fire;
    logic        up1_fire;
    logic        lock_up1;
    int unsigned lock_left;

    // Beats that follow the first beat of a write burst
    function automatic int unsigned beats_after_first(input kl_req_t req);
        if (!req.wen || (req.size <= kl_size_t'(3))) begin
            return 0;
        end
        return (1 << (req.size - kl_size_t'(3))) - 1;
    endfunction

    assign up0_fire = up0_req_valid && up0_req_ready;
    assign up1_fire = up1_req_valid && up1_req_ready;

    // Burst lock as seen from the uplink handshakes alone
    always_ff @(posedge clk) begin
        if (rst) begin
            lock_up1 <= 1'b0;
            lock_left <= 0;
        end else if (lock_left == 0) begin
            if (up0_fire) begin
                lock_up1 <= 1'b0;
                lock_left <= beats_after_first(up0_req);
            end else if (up1_fire) begin
                lock_up1 <= 1'b1;
                lock_left <= beats_after_first(up1_req);
            end
        end else if (lock_up1 ? up1_fire : up0_fire) begin
            lock_left <= lock_left - 1;
        end
    end

    // A beat offered without ready keeps valid and payload until it transfers
    up0_req_stable: assert property (@(posedge clk) disable iff (rst)
        up0_req_valid && !up0_req_ready |=> up0_req_valid && $stable(up0_req))
        else begin
            $error("up0 request changed before its transfer");
            fail_count++;
        end
    up1_req_stable: assert property (@(posedge clk) disable iff (rst)
        up1_req_valid && !up1_req_ready |=> up1_req_valid && $stable(up1_req))
        else begin
            $error("up1 request changed before its transfer");
            fail_count++;
        end
    dn_resp_stable: assert property (@(posedge clk) disable iff (rst)
        dn_resp_valid && !dn_resp_ready |=> dn_resp_valid && $stable(dn_resp))
        else begin
            $error("RAM response changed under back-pressure");
            fail_count++;
        end

    // While a write burst holds the channel, the other uplink never sees ready
    burst_lock_held: assert property (@(posedge clk) disable iff (rst)
        (lock_left != 0) |-> (lock_up1 ? !up0_req_ready : !up1_req_ready))
        else begin
            $error("request channel switched during a write burst");
            fail_count++;
        end

    // A response reaches only the uplink that its dstid names
    resp_routed: assert property (@(posedge clk) disable iff (rst)
        (!up0_resp_valid || (dn_resp.dstid == UP0_SRC_ID)) &&
        (!up1_resp_valid || (dn_resp.dstid == UP1_SRC_ID)))
        else begin
            $error("response valid on an uplink its dstid does not name");
            fail_count++;
        end

endmodule

bind kl_arbiter_2by1 kl_subsys_sva #(
    .UP0_SRC_ID (UP0_SRC_ID),
    .UP1_SRC_ID (UP1_SRC_ID)
) kl_subsys_sva_inst (
    .clk            (clk),
    .rst            (rst),
    .up0_req        (up0_req),
    .up0_req_valid  (up0_req_valid),
    .up0_req_ready  (up0_req_ready),
    .up1_req        (up1_req),
    .up1_req_valid  (up1_req_valid),
    .up1_req_ready  (up1_req_ready),
    .up0_resp_valid (up0_resp_valid),
    .up1_resp_valid (up1_resp_valid),
    .dn_resp        (dn_resp),
    .dn_resp_valid  (dn_resp_valid),
    .dn_resp_ready  (dn_resp_ready)
);

`default_nettype wire

// File: verif/tb_kl_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_kl_subsys;

    import kl_pkg::*;

    localparam kl_src_id_t UP0_ID = 5'd0;
    localparam kl_src_id_t UP1_ID = 5'd1;
    localparam int MEM_WORDS = 256;
    // The directed tests take well under two hundred cycles
    localparam int MAX_CYCLES = 2000;

    logic     clk = 1'b0;
    logic     rst;
    kl_req_t  up0_req;
    logic     up0_req_valid;
    logic     up0_req_ready;
    kl_resp_t up0_resp;
    logic     up0_resp_valid;
    logic     up0_resp_ready;
    kl_req_t  up1_req;
    logic     up1_req_valid;
    logic     up1_req_ready;
    kl_resp_t up1_resp;
    logic     up1_resp_valid;
    logic     up1_resp_ready;

    kl_data_t ref_mem [MEM_WORDS];
    int       order [$];
    int       errors = 0;
    int       checks = 0;
    int       cycles = 0;

    kl_subsys_top #(
        .MAX_BURST_WIDTH (5),
        .UP0_SRC_ID      (UP0_ID),
        .UP1_SRC_ID      (UP1_ID),
        .MEM_WORDS       (MEM_WORDS)
    ) kl_subsys_top_inst (
        .clk            (clk),
        .rst            (rst),
        .up0_req        (up0_req),
        .up0_req_valid  (up0_req_valid),
        .up0_req_ready  (up0_req_ready),
        .up0_resp       (up0_resp),
        .up0_resp_valid (up0_resp_valid),
        .up0_resp_ready (up0_resp_ready),
        .up1_req        (up1_req),
        .up1_req_valid  (up1_req_valid),
        .up1_req_ready  (up1_req_ready),
        .up1_resp       (up1_resp),
        .up1_resp_valid (up1_resp_valid),
        .up1_resp_ready (up1_resp_ready)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // One beat per 64-bit word, so sizes above 3 double the count per step
    function automatic int beats_for_size(input kl_size_t size);
        if (int'(size) <= 3) begin
            return 1;
        end
        return 1 << (int'(size) - 3);
    endfunction

    function automatic int word_of(input kl_addr_t addr);
        return int'(addr >> 3) % MEM_WORDS;
    endfunction

    function automatic kl_data_t rand_word();
        return {$urandom, $urandom};
    endfunction

    task automatic set_req(input int port, input kl_req_t r, input logic valid);
        if (port == 0) begin
            up0_req = r;
            up0_req_valid = valid;
        end else begin
            up1_req = r;
            up1_req_valid = valid;
        end
    endtask

    task automatic set_resp_ready(input int port, input logic rdy);
        if (port == 0) begin
            up0_resp_ready = rdy;
        end else begin
            up1_resp_ready = rdy;
        end
    endtask

    function automatic logic req_ready_of(input int port);
        return (port == 0) ? up0_req_ready : up1_req_ready;
    endfunction

    function automatic logic resp_valid_of(input int port);
        return (port == 0) ? up0_resp_valid : up1_resp_valid;
    endfunction

    function automatic kl_resp_t resp_of(input int port);
        return (port == 0) ? up0_resp : up1_resp;
    endfunction

    // Offers one beat from the falling edge and holds it until ready.
    // Outputs are sampled 10 ns into the low phase, once the inputs have settled
    task automatic send_beat(input int port, input kl_req_t r);
        @(negedge clk);
        set_req(port, r, 1'b1);
        #10;
        while (!req_ready_of(port)) begin
            @(negedge clk);
            #10;
        end
        if (r.wen) begin
            check("up0_resp_valid", 64'(up0_resp_valid), 64'(0));
            check("up1_resp_valid", 64'(up1_resp_valid), 64'(0));
        end
        @(posedge clk);
        order.push_back(port);
    endtask

    task automatic master_write(input int port, input kl_addr_t addr, input kl_size_t size,
                                input kl_data_t data [$], input logic [7:0] mask [$]);
        kl_req_t r;
        int      n;
        int      w;
        n = beats_for_size(size);
        for (int i = 0; i < n; i++) begin
            r = '0;
            r.addr = addr + kl_addr_t'(8 * i);
            r.wen = 1'b1;
            r.wdata = data[i];
            r.wmask = mask[i];
            r.size = size;
            send_beat(port, r);
            w = word_of(r.addr);
            for (int b = 0; b < 8; b++) begin
                if (mask[i][b]) begin
                    ref_mem[w][8*b +: 8] = data[i][8*b +: 8];
                end
            end
        end
        @(negedge clk);
        set_req(port, '0, 1'b0);
    endtask

    // With stall set, resp_ready is dropped at random
    task automatic master_read(input int port, input kl_addr_t addr, input kl_size_t size,
                               input kl_src_id_t id, input logic stall);
        kl_req_t  r;
        kl_resp_t rsp;
        int       n;
        int       got;
        int       polls;
        logic     rdy;
        n = beats_for_size(size);
        r = '0;
        r.addr = addr;
        r.size = size;
        send_beat(port, r);
        got = 0;
        polls = 0;
        while (got < n) begin
            @(negedge clk);
            set_req(port, '0, 1'b0);
            rdy = stall ? 1'($urandom % 2) : 1'b1;
            set_resp_ready(port, rdy);
            #10;
            if (!stall && polls == 0) begin
                // First beat is due one cycle after the request transfer
                check($sformatf("up%0d_resp_valid", port), 64'(resp_valid_of(port)), 64'(1));
            end
            check($sformatf("up%0d_resp_valid", 1 - port), 64'(resp_valid_of(1 - port)), 64'(0));
            if (resp_valid_of(port) && rdy) begin
                rsp = resp_of(port);
                check($sformatf("up%0d_resp.rdata", port), rsp.rdata,
                      ref_mem[(word_of(addr) + got) % MEM_WORDS]);
                check($sformatf("up%0d_resp.dstid", port), 64'(rsp.dstid), 64'(id));
                check($sformatf("up%0d_resp.size", port), 64'(rsp.size), 64'(size));
                got++;
            end
            polls++;
        end
        @(negedge clk);
        set_resp_ready(port, 1'b1);
        #10;
        check($sformatf("up%0d_resp_valid", port), 64'(resp_valid_of(port)), 64'(0));
    endtask

    task automatic test_reset();
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            #10;
            check("up0_resp_valid", 64'(up0_resp_valid), 64'(0));
            check("up1_resp_valid", 64'(up1_resp_valid), 64'(0));
            check("up0_req_ready", 64'(up0_req_ready), 64'(0));
            check("up1_req_ready", 64'(up1_req_ready), 64'(0));
        end
    endtask

    task automatic test_single();
        kl_data_t   d [$];
        logic [7:0] m [$];
        d.push_back(rand_word());
        m.push_back(8'hff);
        master_write(0, 32'h40, 3'd3, d, m);
        master_read(0, 32'h40, 3'd3, UP0_ID, 1'b0);
        master_read(1, 32'h40, 3'd3, UP1_ID, 1'b0);
    endtask

    task automatic test_mask();
        kl_data_t   d [$];
        logic [7:0] m [$];
        d.push_back(64'h0123_4567_89ab_cdef);
        m.push_back(8'hff);
        master_write(0, 32'h80, 3'd3, d, m);
        d[0] = rand_word();
        m[0] = 8'($urandom);
        master_write(0, 32'h80, 3'd3, d, m);
        master_read(0, 32'h80, 3'd3, UP0_ID, 1'b0);
    endtask

    task automatic test_burst_cross();
        kl_data_t   d [$];
        logic [7:0] m [$];
        for (int i = 0; i < 8; i++) begin
            d.push_back(rand_word());
            m.push_back(8'hff);
        end
        master_write(1, 32'h100, 3'd6, d, m);
        master_read(0, 32'h100, 3'd6, UP0_ID, 1'b0);
    endtask

    // The uplink granted last loses the next tie, and a write burst keeps its lock
    task automatic arbitrate_pair(input int first);
        kl_data_t   burst_d [$];
        logic [7:0] burst_m [$];
        kl_data_t   one_d [$];
        logic [7:0] one_m [$];
        int         exp_order [$];
        for (int i = 0; i < 4; i++) begin
            burst_d.push_back(rand_word());
            burst_m.push_back(8'hff);
        end
        one_d.push_back(rand_word());
        one_m.push_back(8'hff);
        // Leave the other uplink as the one granted last
        master_write(1 - first, 32'h200 + kl_addr_t'(8 * first), 3'd3, one_d, one_m);
        order.delete();
        fork
            master_write(first, 32'h300 + kl_addr_t'(64 * first), 3'd5, burst_d, burst_m);
            master_write(1 - first, 32'h3c0, 3'd3, one_d, one_m);
        join
        for (int i = 0; i < 4; i++) begin
            exp_order.push_back(first);
        end
        exp_order.push_back(1 - first);
        check("grant order length", 64'(order.size()), 64'(5));
        for (int i = 0; i < 5 && i < order.size(); i++) begin
            check("grant order", 64'(order[i]), 64'(exp_order[i]));
        end
    endtask

    initial begin
        void'($urandom(61550));
        rst = 1'b1;
        up0_req = '0;
        up0_req_valid = 1'b0;
        up0_resp_ready = 1'b1;
        up1_req = '0;
        up1_req_valid = 1'b0;
        up1_resp_ready = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_single();
        test_mask();
        test_burst_cross();
        arbitrate_pair(0);
        arbitrate_pair(1);
        master_read(0, 32'h300, 3'd5, UP0_ID, 1'b1);
        errors += kl_subsys_top_inst.kl_arbiter_2by1_inst.kl_subsys_sva_inst.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: kl_subsys.f
common/kl_pkg.sv
rtl/round_robin_arbiter.sv
kl_arbiter/kl_arbiter_2by1.sv
rtl/kl_ram.sv
rtl/kl_subsys_top.sv
verif/kl_subsys_sva.sv
verif/tb_kl_subsys.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_kl_subsys
FILELIST   := kl_subsys.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := ERRORS FOUND

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
